//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_rob
FILELIST  ?= tb.f
PASS_TEXT := TEST OK

.PHONY: sim clean

# build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

//--- hdl/rob_ctrl_if.sv
// ======================================================================
// control bundle between the inner reorder buffer blocks
// one modport per block; pointers, allocation, retire slots,
// head window contents and the squash result
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

interface rob_ctrl_if;
    import rob_pkg::*;

    // pointer state
    rob_idx_t                        head;
    rob_idx_t                        tail;
    logic                            alloc_en;
    rob_idx_t                        alloc_idx;

    // retire selection
    logic         [`ROB_COMMIT_W-1:0] retire_en;

    // table view at head and head+1
    commit_slot_t [`ROB_COMMIT_W-1:0] head_entries;
    logic         [`ROB_COMMIT_W-1:0] head_valid;
    logic         [`ROB_COMMIT_W-1:0] head_ready;
    logic         [`ROB_DEPTH-1:0]    valid_vec;

    // squash result
    logic         [`ROB_DEPTH-1:0]    squash_mask;
    rob_count_t                       squash_count;

    modport table_mp (
        input  head, alloc_en, alloc_idx, retire_en, squash_mask,
        output head_entries, head_valid, head_ready, valid_vec
    );

    modport retire_mp (
        input  head_entries, head_valid, head_ready,
        output retire_en
    );

    modport squash_mp (
        input  tail, valid_vec,
        output squash_mask, squash_count
    );

    modport pointer_mp (
        input  retire_en, squash_count,
        output head, tail, alloc_en, alloc_idx
    );

endinterface

`default_nettype wire

//--- hdl/rob_entry_table.sv
// ======================================================================
// reorder buffer entry storage
// written at the tail on allocation, marked ready by writeback,
// invalidated by retirement and by a squash mask; exports the two
// entries at head and the valid bit of every entry
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_entry_table (
    input  logic                              clock_i,
    input  logic                              reset_i,
    // dispatch fields
    input  logic                              disp_rd_wen_i,
    input  rob_pkg::arch_reg_t                disp_rd_arch_i,
    input  rob_pkg::phys_reg_t                disp_new_prf_i,
    input  rob_pkg::phys_reg_t                disp_old_prf_i,
    // writeback ports
    input  logic              [`ROB_WB_W-1:0] wb_valid_i,
    input  rob_pkg::rob_idx_t [`ROB_WB_W-1:0] wb_rob_idx_i,
    rob_ctrl_if.table_mp                      ctrl
);
    import rob_pkg::*;

    rob_entry_t                   entry_q [`ROB_DEPTH];
    rob_idx_t [`ROB_COMMIT_W-1:0] win_idx;

    // ==================================================================
    // head window
    // ==================================================================
    always_comb begin
        for (int i = 0; i < `ROB_COMMIT_W; i++) begin
            // wraps naturally through the index width
            win_idx[i] = ctrl.head + rob_idx_t'(i);
            ctrl.head_valid[i]   = entry_q[win_idx[i]].valid;
            ctrl.head_ready[i]   = entry_q[win_idx[i]].ready;
            ctrl.head_entries[i] = '{
                rd_wen:  entry_q[win_idx[i]].rd_wen,
                rd_arch: entry_q[win_idx[i]].rd_arch,
                new_prf: entry_q[win_idx[i]].new_prf,
                old_prf: entry_q[win_idx[i]].old_prf
            };
        end
    end

    // valid bits for the squash walk
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            ctrl.valid_vec[i] = entry_q[i].valid;
        end
    end

    // ==================================================================
    // entry updates, later statements take priority
    // ==================================================================
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entry_q[i].valid <= 1'b0;
                entry_q[i].ready <= 1'b0;
            end
        end else begin
            // writeback marks only live entries
            for (int w = 0; w < `ROB_WB_W; w++) begin
                if (wb_valid_i[w] && entry_q[wb_rob_idx_i[w]].valid) begin
                    entry_q[wb_rob_idx_i[w]].ready <= 1'b1;
                end
            end
            // retired slots leave the window
            for (int i = 0; i < `ROB_COMMIT_W; i++) begin
                if (ctrl.retire_en[i]) begin
                    entry_q[win_idx[i]].valid <= 1'b0;
                end
            end
            // squash beats a same-cycle writeback
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (ctrl.squash_mask[i]) begin
                    entry_q[i].valid <= 1'b0;
                    entry_q[i].ready <= 1'b0;
                end
            end
            // new entry at the tail, not ready yet
            if (ctrl.alloc_en) begin
                entry_q[ctrl.alloc_idx] <= '{
                    valid:   1'b1,
                    ready:   1'b0,
                    rd_wen:  disp_rd_wen_i,
                    rd_arch: disp_rd_arch_i,
                    new_prf: disp_new_prf_i,
                    old_prf: disp_old_prf_i
                };
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rob_pkg.sv
// ======================================================================
// shared types of the reorder buffer
// index, count and register number types plus the entry layout;
// modules import it in their body, ports use scoped names
// ======================================================================
`default_nettype none

`include "rob_macros.svh"

package rob_pkg;

    // entry index, wraps at the depth
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // occupancy, needs one more bit to hold a full buffer
    typedef logic [$clog2(`ROB_DEPTH+1)-1:0] rob_count_t;

    // register numbers
    typedef logic [$clog2(`ROB_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`ROB_PHYS_REGS)-1:0] phys_reg_t;

    // one stored entry
    typedef struct packed {
        logic      valid;
        logic      ready;
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
    } rob_entry_t;

    // payload handed to the retire unit, no status bits
    typedef struct packed {
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
    } commit_slot_t;

endpackage

`default_nettype wire

//--- hdl/rob_pointer_ctrl.sv
// ======================================================================
// head, tail and occupancy control
// grants dispatch when not full and no squash is pending, advances
// head by the retired slots and rewinds the tail on a mispredict
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_pointer_ctrl (
    input  logic                clock_i,
    input  logic                reset_i,
    input  logic                disp_valid_i,
    input  logic                mispredict_i,
    input  rob_pkg::rob_idx_t   mispredict_idx_i,
    rob_ctrl_if.pointer_mp      ctrl,
    output logic                disp_ready_o,
    output logic                disp_alloc_o,
    output rob_pkg::rob_idx_t   disp_rob_idx_o,
    output rob_pkg::rob_count_t disp_space_o
);
    import rob_pkg::*;

    rob_idx_t   head_q;
    rob_idx_t   tail_q;
    rob_count_t count_q;
    rob_count_t retire_num;
    logic       full;

    // ==================================================================
    // dispatch grant
    // ==================================================================
    assign full           = (count_q == rob_count_t'(`ROB_DEPTH));
    assign disp_ready_o   = ~full;
    assign disp_alloc_o   = disp_valid_i & ~full & ~mispredict_i;
    assign disp_rob_idx_o = tail_q;
    assign disp_space_o   = rob_count_t'(`ROB_DEPTH) - count_q;

    // to the entry table
    assign ctrl.alloc_en  = disp_alloc_o;
    assign ctrl.alloc_idx = tail_q;
    assign ctrl.head      = head_q;
    assign ctrl.tail      = tail_q;

    assign retire_num = rob_count_t'($countones(ctrl.retire_en));

    // ==================================================================
    // pointer registers
    // ==================================================================
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q <= head_q + rob_idx_t'(retire_num);
            // squash rewinds to just past the branch
            if (mispredict_i) begin
                tail_q <= mispredict_idx_i + 1'b1;
            end else if (disp_alloc_o) begin
                tail_q <= tail_q + 1'b1;
            end
            // squash_count is zero outside a mispredict cycle
            count_q <= count_q + rob_count_t'(disp_alloc_o) - retire_num
                       - ctrl.squash_count;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rob_retire_unit.sv
// ======================================================================
// in-order retirement at the head
// picks up to two slots from the head window each cycle and puts
// them on the registered commit outputs one edge later
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_retire_unit (
    input  logic                                  clock_i,
    input  logic                                  reset_i,
    input  logic                                  mispredict_i,
    rob_ctrl_if.retire_mp                         ctrl,
    output logic               [`ROB_COMMIT_W-1:0] commit_valid_o,
    output logic               [`ROB_COMMIT_W-1:0] commit_rd_wen_o,
    output rob_pkg::arch_reg_t [`ROB_COMMIT_W-1:0] commit_rd_arch_o,
    output rob_pkg::phys_reg_t [`ROB_COMMIT_W-1:0] commit_new_prf_o,
    output rob_pkg::phys_reg_t [`ROB_COMMIT_W-1:0] commit_old_prf_o
);

    // ==================================================================
    // slot selection
    // ==================================================================
    // a slot goes only if every older slot goes too;
    // a mispredict cycle retires nothing
    always_comb begin
        logic chain;
        chain = ~mispredict_i;
        for (int i = 0; i < `ROB_COMMIT_W; i++) begin
            chain = chain & ctrl.head_valid[i] & ctrl.head_ready[i];
            ctrl.retire_en[i] = chain;
        end
    end

    // ==================================================================
    // commit registers
    // ==================================================================
    // one-cycle pulse per retired slot
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            commit_valid_o <= '0;
        end else begin
            commit_valid_o <= ctrl.retire_en;
        end
    end

    // payload, only meaningful with its valid bit
    always_ff @(posedge clock_i) begin
        for (int i = 0; i < `ROB_COMMIT_W; i++) begin
            if (ctrl.retire_en[i]) begin
                commit_rd_wen_o[i]  <= ctrl.head_entries[i].rd_wen;
                commit_rd_arch_o[i] <= ctrl.head_entries[i].rd_arch;
                commit_new_prf_o[i] <= ctrl.head_entries[i].new_prf;
                commit_old_prf_o[i] <= ctrl.head_entries[i].old_prf;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rob_squash_unit.sv
// ======================================================================
// mispredict squash mask
// walks from the entry after the mispredicted one up to the tail and
// marks every live entry on the way; combinational, zero when idle
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_squash_unit (
    input  logic              mispredict_i,
    input  rob_pkg::rob_idx_t mispredict_idx_i,
    rob_ctrl_if.squash_mp     ctrl
);
    import rob_pkg::*;

    always_comb begin
        rob_idx_t   idx;
        logic       done;
        rob_count_t cnt;
        ctrl.squash_mask = '0;
        cnt  = '0;
        done = ~mispredict_i;
        // at most depth-1 entries are younger than the branch
        for (int j = 1; j < `ROB_DEPTH; j++) begin
            idx = mispredict_idx_i + rob_idx_t'(j);
            // reaching the tail ends the walk
            if (idx == ctrl.tail) begin
                done = 1'b1;
            end
            if (!done && ctrl.valid_vec[idx]) begin
                ctrl.squash_mask[idx] = 1'b1;
                cnt = cnt + 1'b1;
            end
        end
        ctrl.squash_count = cnt;
    end

endmodule

`default_nettype wire

//--- hdl/rob_top.sv
// ======================================================================
// reorder buffer top level
// 16 entries, one dispatch, two writeback ports, up to two commits
// per cycle; connects the table, retire, squash and pointer blocks
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_top (
    input  logic                                   clock_i,
    input  logic                                   reset_i,
    // dispatch
    input  logic                                   disp_valid_i,
    input  logic                                   disp_rd_wen_i,
    input  rob_pkg::arch_reg_t                     disp_rd_arch_i,
    input  rob_pkg::phys_reg_t                     disp_new_prf_i,
    input  rob_pkg::phys_reg_t                     disp_old_prf_i,
    output logic                                   disp_ready_o,
    output logic                                   disp_alloc_o,
    output rob_pkg::rob_idx_t                      disp_rob_idx_o,
    output rob_pkg::rob_count_t                    disp_space_o,
    // writeback
    input  logic               [`ROB_WB_W-1:0]     wb_valid_i,
    input  rob_pkg::rob_idx_t  [`ROB_WB_W-1:0]     wb_rob_idx_i,
    // branch recovery
    input  logic                                   mispredict_i,
    input  rob_pkg::rob_idx_t                      mispredict_idx_i,
    // commit
    output logic               [`ROB_COMMIT_W-1:0] commit_valid_o,
    output logic               [`ROB_COMMIT_W-1:0] commit_rd_wen_o,
    output rob_pkg::arch_reg_t [`ROB_COMMIT_W-1:0] commit_rd_arch_o,
    output rob_pkg::phys_reg_t [`ROB_COMMIT_W-1:0] commit_new_prf_o,
    output rob_pkg::phys_reg_t [`ROB_COMMIT_W-1:0] commit_old_prf_o
);

    rob_ctrl_if ctrl ();

    rob_entry_table u_table (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .disp_rd_wen_i  (disp_rd_wen_i),
        .disp_rd_arch_i (disp_rd_arch_i),
        .disp_new_prf_i (disp_new_prf_i),
        .disp_old_prf_i (disp_old_prf_i),
        .wb_valid_i     (wb_valid_i),
        .wb_rob_idx_i   (wb_rob_idx_i),
        .ctrl           (ctrl.table_mp)
    );

    rob_retire_unit u_retire (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .mispredict_i     (mispredict_i),
        .ctrl             (ctrl.retire_mp),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_wen_o  (commit_rd_wen_o),
        .commit_rd_arch_o (commit_rd_arch_o),
        .commit_new_prf_o (commit_new_prf_o),
        .commit_old_prf_o (commit_old_prf_o)
    );

    rob_squash_unit u_squash (
        .mispredict_i     (mispredict_i),
        .mispredict_idx_i (mispredict_idx_i),
        .ctrl             (ctrl.squash_mp)
    );

    rob_pointer_ctrl u_pointer (
        .clock_i          (clock_i),
        .reset_i          (reset_i),
        .disp_valid_i     (disp_valid_i),
        .mispredict_i     (mispredict_i),
        .mispredict_idx_i (mispredict_idx_i),
        .ctrl             (ctrl.pointer_mp),
        .disp_ready_o     (disp_ready_o),
        .disp_alloc_o     (disp_alloc_o),
        .disp_rob_idx_o   (disp_rob_idx_o),
        .disp_space_o     (disp_space_o)
    );

endmodule

`default_nettype wire

//--- include/rob_macros.svh
// ======================================================================
// reorder buffer sizing macros
// included by the package and by every module that needs a width;
// change the depth or slot counts here only
// ======================================================================
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// number of buffer entries
`define ROB_DEPTH 16

// retire slots per cycle
`define ROB_COMMIT_W 2

// writeback ports from the functional units
`define ROB_WB_W 2

// register file sizes
`define ROB_ARCH_REGS 64
`define ROB_PHYS_REGS 128

`endif

//--- tb.f
+incdir+include
hdl/rob_pkg.sv
hdl/rob_ctrl_if.sv
hdl/rob_entry_table.sv
hdl/rob_retire_unit.sv
hdl/rob_squash_unit.sv
hdl/rob_pointer_ctrl.sv
hdl/rob_top.sv
test/tb_rob.sv

//--- test/tb_rob.sv
// ======================================================================
// directed testbench for the reorder buffer top level
// a queue model in program order predicts every commit; a monitor
// compares each commit slot against it as it appears
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module tb_rob;
    import rob_pkg::*;

    // well above the total length of all tests
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_COUNT   = 40;

    typedef struct {
        rob_idx_t  idx;
        logic      rd_wen;
        arch_reg_t rd_arch;
        phys_reg_t new_prf;
        phys_reg_t old_prf;
    } exp_entry_t;

    logic                                 clock;
    logic                                 reset;
    logic                                 disp_valid;
    logic                                 disp_rd_wen;
    arch_reg_t                            disp_rd_arch;
    phys_reg_t                            disp_new_prf;
    phys_reg_t                            disp_old_prf;
    logic                                 disp_ready;
    logic                                 disp_alloc;
    rob_idx_t                             disp_rob_idx;
    rob_count_t                           disp_space;
    logic      [`ROB_WB_W-1:0]            wb_valid;
    rob_idx_t  [`ROB_WB_W-1:0]            wb_rob_idx;
    logic                                 mispredict;
    rob_idx_t                             mispredict_idx;
    logic      [`ROB_COMMIT_W-1:0]        commit_valid;
    logic      [`ROB_COMMIT_W-1:0]        commit_rd_wen;
    arch_reg_t [`ROB_COMMIT_W-1:0]        commit_rd_arch;
    phys_reg_t [`ROB_COMMIT_W-1:0]        commit_new_prf;
    phys_reg_t [`ROB_COMMIT_W-1:0]        commit_old_prf;

    // model state
    exp_entry_t model_q[$];
    exp_entry_t pend_entry;
    exp_entry_t mon_exp;
    rob_idx_t   model_tail;
    string      test_name;
    integer     seed;
    int         cycle_count = 0;

    rob_top u_dut (
        .clock_i          (clock),
        .reset_i          (reset),
        .disp_valid_i     (disp_valid),
        .disp_rd_wen_i    (disp_rd_wen),
        .disp_rd_arch_i   (disp_rd_arch),
        .disp_new_prf_i   (disp_new_prf),
        .disp_old_prf_i   (disp_old_prf),
        .disp_ready_o     (disp_ready),
        .disp_alloc_o     (disp_alloc),
        .disp_rob_idx_o   (disp_rob_idx),
        .disp_space_o     (disp_space),
        .wb_valid_i       (wb_valid),
        .wb_rob_idx_i     (wb_rob_idx),
        .mispredict_i     (mispredict),
        .mispredict_idx_i (mispredict_idx),
        .commit_valid_o   (commit_valid),
        .commit_rd_wen_o  (commit_rd_wen),
        .commit_rd_arch_o (commit_rd_arch),
        .commit_new_prf_o (commit_new_prf),
        .commit_old_prf_o (commit_old_prf)
    );

    // 4 ns clock
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // ==================================================================
    // reporting
    // ==================================================================
    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                                     test_name, what, expected, actual));
        end
    endtask

    // run limit
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout, the run did not finish within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    // commit monitor, outputs are registered so the falling edge is stable
    always @(negedge clock) begin
        if (!reset) begin
            if (commit_valid[1] && !commit_valid[0]) begin
                report_failure("commit slot 1 fired while slot 0 stayed idle");
            end else begin
                for (int i = 0; i < `ROB_COMMIT_W; i++) begin
                    if (commit_valid[i] && model_q.size() == 0) begin
                        report_failure("a commit appeared with no entry left in the model");
                    end else if (commit_valid[i]) begin
                        mon_exp = model_q.pop_front();
                        check_value("commit_rd_wen_o", 32'(mon_exp.rd_wen),
                                    32'(commit_rd_wen[i]));
                        check_value("commit_rd_arch_o", 32'(mon_exp.rd_arch),
                                    32'(commit_rd_arch[i]));
                        check_value("commit_new_prf_o", 32'(mon_exp.new_prf),
                                    32'(commit_new_prf[i]));
                        check_value("commit_old_prf_o", 32'(mon_exp.old_prf),
                                    32'(commit_old_prf[i]));
                    end
                end
            end
        end
    end

    // ==================================================================
    // stimulus helpers
    // ==================================================================
    // next falling edge, all strobes dropped
    task automatic start_cycle();
        @(negedge clock);
        disp_valid = 1'b0;
        wb_valid   = '0;
        mispredict = 1'b0;
    endtask

    // random fields for one dispatch
    task automatic drive_dispatch();
        logic [31:0] rnd;
        rnd = $random(seed);
        pend_entry.rd_wen  = rnd[0];
        pend_entry.rd_arch = rnd[6:1];
        pend_entry.new_prf = rnd[13:7];
        pend_entry.old_prf = rnd[20:14];
        disp_valid   = 1'b1;
        disp_rd_wen  = pend_entry.rd_wen;
        disp_rd_arch = pend_entry.rd_arch;
        disp_new_prf = pend_entry.new_prf;
        disp_old_prf = pend_entry.old_prf;
    endtask

    // grant is combinational, look a little after the drive
    task automatic settle_dispatch(input logic expect_alloc, output rob_idx_t idx_o);
        #1;
        check_value("disp_alloc_o", 32'(expect_alloc), 32'(disp_alloc));
        idx_o = model_tail;
        if (expect_alloc) begin
            check_value("disp_rob_idx_o", 32'(model_tail), 32'(disp_rob_idx));
            pend_entry.idx = model_tail;
            model_q.push_back(pend_entry);
            model_tail = model_tail + 1'b1;
        end
    endtask

    task automatic dispatch_entry(output rob_idx_t idx_o);
        start_cycle();
        drive_dispatch();
        settle_dispatch(1'b1, idx_o);
    endtask

    task automatic drive_writeback(input logic v0, input rob_idx_t i0,
                                   input logic v1, input rob_idx_t i1);
        start_cycle();
        wb_valid      = {v1, v0};
        wb_rob_idx[0] = i0;
        wb_rob_idx[1] = i1;
    endtask

    task automatic expect_commit(input logic [1:0] mask);
        start_cycle();
        #1;
        check_value("commit_valid_o", 32'(mask), 32'(commit_valid));
    endtask

    // run until the model is empty, then a few idle cycles for strays
    task automatic drain_commits();
        while (model_q.size() != 0) begin
            start_cycle();
            #1;
        end
        repeat (3) begin
            start_cycle();
            #1;
        end
        check_value("disp_space_o", `ROB_DEPTH, 32'(disp_space));
    endtask

    // ==================================================================
    // tests
    // ==================================================================
    task automatic test_reset_state();
        test_name = "reset_state";
        start_cycle();
        #1;
        check_value("commit_valid_o", 0, 32'(commit_valid));
        check_value("disp_ready_o", 1, 32'(disp_ready));
        check_value("disp_space_o", `ROB_DEPTH, 32'(disp_space));
    endtask

    task automatic test_in_order_commit();
        rob_idx_t idx [5];
        test_name = "in_order_commit";
        for (int i = 0; i < 5; i++) begin
            dispatch_entry(idx[i]);
        end
        // youngest first
        for (int i = 4; i >= 0; i--) begin
            drive_writeback(1'b1, idx[i], 1'b0, '0);
        end
        drain_commits();
    endtask

    task automatic test_full();
        rob_idx_t idx_list [`ROB_DEPTH];
        rob_idx_t dummy;
        test_name = "full";
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            dispatch_entry(dummy);
        end
        // 17th dispatch is dropped
        start_cycle();
        drive_dispatch();
        settle_dispatch(1'b0, dummy);
        check_value("disp_ready_o", 0, 32'(disp_ready));
        check_value("disp_space_o", 0, 32'(disp_space));
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            idx_list[i] = model_q[i].idx;
        end
        for (int i = 0; i < `ROB_DEPTH; i += 2) begin
            drive_writeback(1'b1, idx_list[i], 1'b1, idx_list[i+1]);
        end
        drain_commits();
    endtask

    task automatic test_dual_retire();
        rob_idx_t a;
        rob_idx_t b;
        test_name = "dual_retire";
        dispatch_entry(a);
        dispatch_entry(b);
        drive_writeback(1'b1, a, 1'b1, b);
        // ready at the first edge, commit pulse at the second
        expect_commit(2'b00);
        expect_commit(2'b11);
        dispatch_entry(a);
        dispatch_entry(b);
        // head+1 ready alone must wait for head
        drive_writeback(1'b0, '0, 1'b1, b);
        repeat (4) begin
            expect_commit(2'b00);
        end
        drive_writeback(1'b1, a, 1'b0, '0);
        expect_commit(2'b00);
        expect_commit(2'b11);
        drain_commits();
    endtask

    task automatic test_squash();
        rob_idx_t batch [6];
        rob_idx_t dummy;
        test_name = "squash";
        for (int i = 0; i < 6; i++) begin
            dispatch_entry(batch[i]);
        end
        // mispredict on the third entry, dispatch in the same cycle is blocked
        start_cycle();
        mispredict     = 1'b1;
        mispredict_idx = batch[2];
        drive_dispatch();
        settle_dispatch(1'b0, dummy);
        repeat (3) begin
            void'(model_q.pop_back());
        end
        model_tail = batch[2] + 1'b1;
        start_cycle();
        #1;
        check_value("disp_space_o", 32'(`ROB_DEPTH - 3), 32'(disp_space));
        // writebacks to the squashed slots are ignored
        for (int i = 0; i < 6; i += 2) begin
            drive_writeback(1'b1, batch[i], 1'b1, batch[i+1]);
        end
        drain_commits();
        dispatch_entry(dummy);
        // the rewound tail hands out the first squashed slot again
        check_value("disp_rob_idx_o", 32'(batch[3]), 32'(disp_rob_idx));
        drive_writeback(1'b1, dummy, 1'b0, '0);
        drain_commits();
    endtask

    task automatic test_random_order();
        rob_idx_t    pending[$];
        rob_idx_t    new_idx;
        logic [31:0] rnd;
        logic        do_disp;
        int          pos;
        int          n_disp;
        test_name = "random_order";
        n_disp = 0;
        while (n_disp < RANDOM_COUNT || pending.size() > 0) begin
            start_cycle();
            do_disp = 1'b0;
            rnd = $random(seed);
            // model depth is never below the real occupancy
            if (n_disp < RANDOM_COUNT && model_q.size() < `ROB_DEPTH && rnd[3]) begin
                drive_dispatch();
                do_disp = 1'b1;
            end
            for (int w = 0; w < `ROB_WB_W; w++) begin
                rnd = $random(seed);
                if (pending.size() > 0 && rnd[16]) begin
                    pos = int'(rnd[15:0]) % pending.size();
                    wb_valid[w]   = 1'b1;
                    wb_rob_idx[w] = pending[pos];
                    pending.delete(pos);
                end
            end
            if (do_disp) begin
                settle_dispatch(1'b1, new_idx);
                pending.push_back(new_idx);
                n_disp++;
            end
        end
        drain_commits();
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin
        seed           = 32'h646635ef;
        reset          = 1'b1;
        disp_valid     = 1'b0;
        disp_rd_wen    = 1'b0;
        disp_rd_arch   = '0;
        disp_new_prf   = '0;
        disp_old_prf   = '0;
        wb_valid       = '0;
        wb_rob_idx     = '0;
        mispredict     = 1'b0;
        mispredict_idx = '0;
        model_tail     = '0;
        test_name      = "init";
        // two rising edges in reset
        repeat (2) @(negedge clock);
        reset = 1'b0;
        test_reset_state();
        test_in_order_commit();
        test_full();
        test_dual_retire();
        test_squash();
        test_random_order();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
